/* build.f */
+incdir+verilog
verilog/filter_cond_pkg.sv
verilog/packet_fifo.sv
verilog/filter_cond_config.sv
verilog/filter_cond_pipeline.sv
verilog/filter_cond_generator.sv
bench/filter_cond_tb.sv

/* Makefile */
TOP := filter_cond_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f verilog/*.sv verilog/*.svh bench/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

/* bench/filter_cond_tb.sv */
// Testbench for the conditional filter stage; concurrent assertions do the checking.
// Each run sends its end-of-sequence packet last and nothing after it.
// Field values are kept small so that EQ compares hit often.
`timescale 1ns/100ps
`include "filter_cond_settings.svh"

module filter_cond_tb
    import filter_cond_pkg::*;
();

    logic           ap_clk;
    logic           areset_generator;
    logic           start;
    config_beat_t   config_in;
    logic           config_request;
    packet_beat_t   packet_in;
    logic           packet_in_ready;
    packet_beat_t   engine_out;
    logic           engine_out_ready;
    packet_beat_t   control_out;
    logic           control_out_ready;
    logic           done;

    // Reference model state
    memory_packet_t eng_q[$];
    memory_packet_t ctl_q[$];
    memory_packet_t eng_expect;
    memory_packet_t ctl_expect;
    bit             eng_pending;
    bit             ctl_pending;
    bit             saw_backpressure;
    filter_config_t run_cfg;
    bit             stall_outputs;

    filter_cond_generator i_filter_cond_generator (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .config_in        (config_in),
        .config_request   (config_request),
        .packet_in        (packet_in),
        .packet_in_ready  (packet_in_ready),
        .engine_out       (engine_out),
        .engine_out_ready (engine_out_ready),
        .control_out      (control_out),
        .control_out_ready(control_out_ready),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // --------------------
    // Failure reporting
    // --------------------
    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string what);
        abort_run($sformatf("error %0t: %s", $time, what));
    endtask

    // Routing rule; returns whether the packet is forwarded
    function automatic bit apply_rule(memory_packet_t p, filter_config_t c,
                                      output memory_packet_t r);
        logic [`FC_DATA_W-1:0] field;
        bit                    match;
        r = p;
        if (p.meta.seq_state == SEQ_DONE) begin
            r.meta.cmd        = CMD_CONTROL;
            r.meta.route_to   = p.meta.seq_src;
            r.meta.route_from = p.meta.seq_src;
            return 1'b1;
        end
        field = p.data[c.field_index];
        if (c.op == CMP_EQ) begin
            match = (field == c.value);
        end else if (c.op == CMP_GT) begin
            match = (field > c.value);
        end else begin
            match = (field < c.value);
        end
        if (c.conditional_flag) begin
            r.meta.route_to = (match == c.filter_pass) ? c.route_if : c.route_else;
            return 1'b1;
        end
        return (match == c.filter_pass);
    endfunction

    // Model: old heads leave first, then the newly accepted packet is queued
    always @(posedge ap_clk) begin
        memory_packet_t routed;
        if (areset_generator) begin
            eng_q.delete();
            ctl_q.delete();
        end else begin
            if (engine_out.valid && engine_out_ready && eng_q.size() != 0) begin
                void'(eng_q.pop_front());
            end
            if (control_out.valid && control_out_ready && ctl_q.size() != 0) begin
                void'(ctl_q.pop_front());
            end
            if (packet_in.valid && packet_in_ready) begin
                if (apply_rule(packet_in.payload, run_cfg, routed)) begin
                    if (routed.meta.cmd == CMD_CONTROL) begin
                        ctl_q.push_back(routed);
                    end else begin
                        eng_q.push_back(routed);
                    end
                end
            end
            if (!packet_in_ready) begin
                saw_backpressure <= 1'b1;
            end
        end
        eng_pending <= (eng_q.size() != 0);
        ctl_pending <= (ctl_q.size() != 0);
        if (eng_q.size() != 0) begin
            eng_expect <= eng_q[0];
        end
        if (ctl_q.size() != 0) begin
            ctl_expect <= ctl_q[0];
        end
    end

    // --------------------
    // Checks
    // --------------------
    reset_state: assert property (@(posedge ap_clk) $fell(areset_generator) |->
        (done && !config_request && !engine_out.valid && !control_out.valid && packet_in_ready))
        else report_mismatch("outputs wrong after reset");

    start_request: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (start && done) |=> (config_request && !done))
        else report_mismatch("no config request or done still high after start");

    request_pulse: assert property (@(posedge ap_clk) disable iff (areset_generator)
        config_request |=> !config_request)
        else report_mismatch("config_request longer than one cycle");

    engine_order: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (engine_out.valid && engine_out_ready) |->
        (eng_pending && engine_out.payload == eng_expect))
        else report_mismatch("engine_out packet differs from the model");

    control_order: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (control_out.valid && control_out_ready) |->
        (ctl_pending && control_out.payload == ctl_expect))
        else report_mismatch("control_out packet differs from the model");

    engine_class: assert property (@(posedge ap_clk) disable iff (areset_generator)
        engine_out.valid |-> (engine_out.payload.meta.cmd == CMD_ENGINE))
        else report_mismatch("control packet on engine_out");

    control_class: assert property (@(posedge ap_clk) disable iff (areset_generator)
        control_out.valid |-> (control_out.payload.meta.cmd == CMD_CONTROL))
        else report_mismatch("engine packet on control_out");

    engine_hold: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (engine_out.valid && !engine_out_ready) |=>
        (engine_out.valid && $stable(engine_out.payload)))
        else report_mismatch("engine_out payload changed while waiting");

    control_hold: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (control_out.valid && !control_out_ready) |=>
        (control_out.valid && $stable(control_out.payload)))
        else report_mismatch("control_out payload changed while waiting");

    done_drained: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(done) |-> (!eng_pending && !ctl_pending))
        else report_mismatch("done rose with packets still expected");

    done_quiet: assert property (@(posedge ap_clk) disable iff (areset_generator)
        done |-> (!engine_out.valid && !control_out.valid))
        else report_mismatch("output valid while done is high");

    // --------------------
    // Stimulus
    // --------------------
    function automatic memory_packet_t random_packet(bit last, bit mix_cmd);
        memory_packet_t p;
        for (int f = 0; f < `FC_FIELDS; f++) begin
            p.data[f] = $urandom_range(0, 7);
        end
        p.meta.route_to   = 8'($urandom);
        p.meta.route_from = 8'($urandom);
        p.meta.seq_src    = 8'($urandom);
        p.meta.seq_state  = last ? SEQ_DONE : SEQ_RUNNING;
        p.meta.cmd        = (mix_cmd && $urandom_range(0, 1) == 1) ? CMD_CONTROL : CMD_ENGINE;
        return p;
    endfunction

    function automatic filter_config_t make_config(cmp_op_t op, bit pass, bit cond);
        filter_config_t c;
        c.field_index      = 2'($urandom_range(0, `FC_FIELDS - 1));
        c.op               = op;
        c.value            = $urandom_range(1, 6);
        c.filter_pass      = pass;
        c.conditional_flag = cond;
        c.route_if         = 8'($urandom);
        c.route_else       = 8'($urandom);
        return c;
    endfunction

    task automatic send_packet(memory_packet_t p);
        int n;
        packet_in.valid   = 1'b1;
        packet_in.payload = p;
        n = 0;
        while (!packet_in_ready && n < 2000) begin
            @(posedge ap_clk);
            #10;
            n++;
        end
        if (!packet_in_ready) abort_run("input never accepted a packet");
        @(posedge ap_clk);
        #10;
        packet_in.valid = 1'b0;
    endtask

    task automatic run_filter(filter_config_t cfg, int count, bit mix_cmd, bit stall);
        int n;
        int i;
        n = 0;
        while (!done && n < 100) begin
            @(posedge ap_clk);
            #10;
            n++;
        end
        if (!done) abort_run("stage not idle before a new run");
        stall_outputs = stall;
        run_cfg       = cfg;
        start         = 1'b1;
        @(posedge ap_clk);
        #10;
        start = 1'b0;
        n = 0;
        while (!config_request && n < 10) begin
            @(posedge ap_clk);
            #10;
            n++;
        end
        if (!config_request) abort_run("no configuration request after start");
        config_in.valid   = 1'b1;
        config_in.payload = cfg;
        @(posedge ap_clk);
        #10;
        config_in = '0;
        for (i = 0; i < count; i++) begin
            send_packet(random_packet(i == count - 1, mix_cmd));
        end
        n = 0;
        while (!done && n < 5000) begin
            @(posedge ap_clk);
            #10;
            n++;
        end
        if (!done) abort_run("run did not finish in time");
    endtask

    // Output ready, redrawn every cycle; mostly low while stalling
    initial begin
        engine_out_ready  = 1'b0;
        control_out_ready = 1'b0;
        forever begin
            @(posedge ap_clk);
            #10;
            if (stall_outputs) begin
                engine_out_ready  = ($urandom_range(0, 9) == 0);
                control_out_ready = ($urandom_range(0, 9) == 0);
            end else begin
                engine_out_ready  = ($urandom_range(0, 3) != 0);
                control_out_ready = ($urandom_range(0, 3) != 0);
            end
        end
    end

    initial begin
        void'($urandom(32'hf840));
        areset_generator = 1'b1;
        start            = 1'b0;
        config_in        = '0;
        packet_in        = '0;
        run_cfg          = '0;
        stall_outputs    = 1'b0;
        repeat (3) @(posedge ap_clk);
        #10;
        areset_generator = 1'b0;

        run_filter(make_config(CMP_EQ, 1'b1, 1'b0), 20, 1'b0, 1'b0);
        run_filter(make_config(CMP_GT, 1'b0, 1'b0), 20, 1'b0, 1'b0);
        run_filter(make_config(CMP_LT, 1'b1, 1'b0), 20, 1'b0, 1'b0);
        // Conditional routing
        run_filter(make_config(CMP_GT, 1'b1, 1'b1), 20, 1'b0, 1'b0);
        // Mixed engine and control packets
        run_filter(make_config(CMP_LT, 1'b0, 1'b0), 24, 1'b1, 1'b0);
        // Long output stalls
        run_filter(make_config(CMP_EQ, 1'b0, 1'b1), 48, 1'b1, 1'b1);

        if (eng_pending || ctl_pending || !saw_backpressure) begin
            abort_run("packets left over or input never back-pressured at end of test");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule : filter_cond_tb

/* verilog/filter_cond_generator.sv */
// Top of the conditional filter stage: input FIFO, run control, pipeline and two
// output FIFOs. Outputs are valid/ready; payload holds while valid waits for ready.
// packet_in_ready drops while the input FIFO is at its threshold.
`timescale 1ns/100ps

module filter_cond_generator
    import filter_cond_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  logic         start,
    input  config_beat_t config_in,
    output logic         config_request,
    input  packet_beat_t packet_in,
    output logic         packet_in_ready,
    output packet_beat_t engine_out,
    input  logic         engine_out_ready,
    output packet_beat_t control_out,
    input  logic         control_out_ready,
    output logic         done
);

    // Input side
    logic           in_push;
    logic           in_pop;
    memory_packet_t in_head;
    logic           in_empty;
    logic           in_prog_full;

    // Processing
    filter_config_t active_config;
    logic           config_valid;
    logic           sequence_end;
    logic           drained;

    // Output side
    logic           engine_push;
    memory_packet_t engine_data;
    memory_packet_t engine_head;
    logic           engine_empty;
    logic           engine_prog_full;
    logic           control_push;
    memory_packet_t control_data;
    memory_packet_t control_head;
    logic           control_empty;
    logic           control_prog_full;

    assign packet_in_ready = ~in_prog_full;
    assign in_push         = packet_in.valid & packet_in_ready;

    packet_fifo i_input_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (in_push),
        .push_data       (packet_in.payload),
        .pop             (in_pop),
        .head            (in_head),
        .empty           (in_empty),
        .prog_full       (in_prog_full)
    );

    filter_cond_config i_config (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .config_in       (config_in),
        .sequence_end    (sequence_end),
        .drained         (drained),
        .config_request  (config_request),
        .active_config   (active_config),
        .config_valid    (config_valid),
        .done            (done)
    );

    filter_cond_pipeline i_pipeline (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .active_config    (active_config),
        .config_valid     (config_valid),
        .in_head          (in_head),
        .in_empty         (in_empty),
        .engine_prog_full (engine_prog_full),
        .control_prog_full(control_prog_full),
        .engine_empty     (engine_empty),
        .control_empty    (control_empty),
        .in_pop           (in_pop),
        .engine_push      (engine_push),
        .engine_data      (engine_data),
        .control_push     (control_push),
        .control_data     (control_data),
        .sequence_end     (sequence_end),
        .drained          (drained)
    );

    // --------------------
    // Output FIFOs
    // --------------------
    packet_fifo i_engine_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (engine_push),
        .push_data       (engine_data),
        .pop             (engine_out_ready),
        .head            (engine_head),
        .empty           (engine_empty),
        .prog_full       (engine_prog_full)
    );

    packet_fifo i_control_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (control_push),
        .push_data       (control_data),
        .pop             (control_out_ready),
        .head            (control_head),
        .empty           (control_empty),
        .prog_full       (control_prog_full)
    );

    assign engine_out.valid    = ~engine_empty;
    assign engine_out.payload  = engine_head;
    assign control_out.valid   = ~control_empty;
    assign control_out.payload = control_head;

endmodule : filter_cond_generator

/* verilog/filter_cond_pipeline.sv */
// Three register stages: capture, compare, route. Pop to output push is three cycles.
// Pops stop once an end-of-sequence packet is taken, until config_valid drops.
// Result data is not rewritten; only route, cmd and the drop decision change.
`timescale 1ns/100ps
`include "filter_cond_settings.svh"

module filter_cond_pipeline
    import filter_cond_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  filter_config_t active_config,
    input  logic           config_valid,
    input  memory_packet_t in_head,
    input  logic           in_empty,
    input  logic           engine_prog_full,
    input  logic           control_prog_full,
    input  logic           engine_empty,
    input  logic           control_empty,
    output logic           in_pop,
    output logic           engine_push,
    output memory_packet_t engine_data,
    output logic           control_push,
    output memory_packet_t control_data,
    output logic           sequence_end,
    output logic           drained
);

    logic                  end_seen;
    logic                  s1_valid;
    memory_packet_t        s1_packet;
    logic [`FC_DATA_W-1:0] s1_field;
    logic                  s1_match;
    logic                  s2_valid;
    logic                  s2_match;
    memory_packet_t        s2_packet;
    logic                  s2_pass;
    logic                  s2_end;
    logic                  s2_forward;
    memory_packet_t        s2_routed;
    logic                  s3_engine;
    logic                  s3_control;
    logic                  s3_end;
    memory_packet_t        s3_packet;

    // --------------------
    // Input side
    // --------------------
    assign in_pop = config_valid & ~in_empty & ~engine_prog_full & ~control_prog_full
                    & ~end_seen;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            end_seen <= 1'b0;
        end else if (~config_valid) begin
            end_seen <= 1'b0;
        end else if (in_pop && (in_head.meta.seq_state == SEQ_DONE)) begin
            end_seen <= 1'b1;
        end
    end

    // Stage valids
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            s3_engine  <= 1'b0;
            s3_control <= 1'b0;
            s3_end     <= 1'b0;
        end else begin
            s1_valid   <= in_pop;
            s2_valid   <= s1_valid;
            s3_engine  <= s2_valid & s2_forward & (s2_routed.meta.cmd != CMD_CONTROL);
            s3_control <= s2_valid & s2_forward & (s2_routed.meta.cmd == CMD_CONTROL);
            s3_end     <= s2_valid & s2_end;
        end
    end

    // --------------------
    // Compare
    // --------------------
    assign s1_field = s1_packet.data[active_config.field_index];

    always_comb begin
        case (active_config.op)
            CMP_EQ:  s1_match = (s1_field == active_config.value);
            CMP_GT:  s1_match = (s1_field > active_config.value);
            CMP_LT:  s1_match = (s1_field < active_config.value);
            default: s1_match = 1'b0;
        endcase
    end

    // --------------------
    // Route
    // --------------------
    assign s2_pass = (s2_match == active_config.filter_pass);
    assign s2_end  = (s2_packet.meta.seq_state == SEQ_DONE);

    always_comb begin
        s2_routed  = s2_packet;
        s2_forward = s2_pass;
        if (s2_end) begin
            // End packet returns to its sequence source
            s2_forward                = 1'b1;
            s2_routed.meta.cmd        = CMD_CONTROL;
            s2_routed.meta.route_to   = s2_packet.meta.seq_src;
            s2_routed.meta.route_from = s2_packet.meta.seq_src;
        end else if (active_config.conditional_flag) begin
            s2_forward              = 1'b1;
            s2_routed.meta.route_to = s2_pass ? active_config.route_if
                                              : active_config.route_else;
        end
    end

    // Payload registers
    always_ff @(posedge ap_clk) begin
        if (in_pop) begin
            s1_packet <= in_head;
        end
        s2_match  <= s1_match;
        s2_packet <= s1_packet;
        s3_packet <= s2_routed;
    end

    assign engine_push  = s3_engine;
    assign engine_data  = s3_packet;
    assign control_push = s3_control;
    assign control_data = s3_packet;
    assign sequence_end = s3_end;

    // Nothing in flight and nothing waiting at the outputs
    assign drained = ~s1_valid & ~s2_valid & ~s3_engine & ~s3_control
                     & engine_empty & control_empty;

endmodule : filter_cond_pipeline

/* verilog/filter_cond_config.sv */
// Run control of the filter stage: start, config request and latch, drain, done.
// A config beat is taken in the request cycle or any cycle after it, until latched.
// start is only honoured while done is high.
`timescale 1ns/100ps

module filter_cond_config
    import filter_cond_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           start,
    input  config_beat_t   config_in,
    input  logic           sequence_end,
    input  logic           drained,
    output logic           config_request,
    output filter_config_t active_config,
    output logic           config_valid,
    output logic           done
);

    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        WAIT_CONFIG,
        ACTIVE,
        DRAIN
    } run_state_t;

    run_state_t state;
    run_state_t next_state;
    logic       take_config;

    assign take_config = config_in.valid & ((state == REQUEST) | (state == WAIT_CONFIG));

    // --------------------
    // Run FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = REQUEST;
                end
            end
            REQUEST: begin
                next_state = config_in.valid ? ACTIVE : WAIT_CONFIG;
            end
            WAIT_CONFIG: begin
                if (config_in.valid) begin
                    next_state = ACTIVE;
                end
            end
            // Held until the end packet leaves the pipeline
            ACTIVE: begin
                if (sequence_end) begin
                    next_state = DRAIN;
                end
            end
            DRAIN: begin
                if (drained) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // Config latch, cleared as the run completes
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            active_config <= '0;
        end else if (take_config) begin
            active_config <= config_in.payload;
        end else if ((state == DRAIN) && drained) begin
            active_config <= '0;
        end
    end

    assign config_request = (state == REQUEST);
    assign config_valid   = (state == ACTIVE);
    assign done           = (state == IDLE);

endmodule : filter_cond_config

/* verilog/packet_fifo.sv */
// Show-ahead synchronous FIFO of memory packets; head is the oldest entry.
// Pop on empty and push on full are dropped silently, so callers watch prog_full.
// DEPTH must be at least 2.
`timescale 1ns/100ps
`include "filter_cond_settings.svh"

module packet_fifo
    import filter_cond_pkg::*;
#(
    parameter int DEPTH       = `FC_FIFO_DEPTH,
    parameter int PROG_THRESH = `FC_PROG_THRESH
) (
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           push,
    input  memory_packet_t push_data,
    input  logic           pop,
    output memory_packet_t head,
    output logic           empty,
    output logic           prog_full
);

    localparam int PTR_W   = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    memory_packet_t     mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               push_ok;
    logic               pop_ok;

    assign push_ok = push & (count != COUNT_W'(DEPTH));
    assign pop_ok  = pop & ~empty;

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and fill level
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head      = mem[rd_ptr];
    assign empty     = (count == '0);
    assign prog_full = (count >= COUNT_W'(PROG_THRESH));

endmodule : packet_fifo

/* verilog/filter_cond_pkg.sv */
// Packet, header and filter configuration types of the conditional filter stage.
// Field widths come from the settings header.
`include "filter_cond_settings.svh"

package filter_cond_pkg;

    typedef enum logic [0:0] {
        SEQ_RUNNING = 1'b0,
        SEQ_DONE    = 1'b1
    } seq_state_t;

    typedef enum logic [0:0] {
        CMD_ENGINE  = 1'b0,
        CMD_CONTROL = 1'b1
    } cmd_t;

    // Unsigned compare
    typedef enum logic [1:0] {
        CMP_EQ = 2'd0,
        CMP_GT = 2'd1,
        CMP_LT = 2'd2
    } cmp_op_t;

    // --------------------
    // Memory packet
    // --------------------
    typedef struct packed {
        logic [`FC_ROUTE_W-1:0] route_to;
        logic [`FC_ROUTE_W-1:0] route_from;
        logic [`FC_ROUTE_W-1:0] seq_src;
        seq_state_t             seq_state;
        cmd_t                   cmd;
    } packet_meta_t;

    typedef struct packed {
        logic [`FC_FIELDS-1:0][`FC_DATA_W-1:0] data;
        packet_meta_t                          meta;
    } memory_packet_t;

    typedef struct packed {
        logic           valid;
        memory_packet_t payload;
    } packet_beat_t;

    // --------------------
    // Filter configuration
    // --------------------
    typedef struct packed {
        logic [$clog2(`FC_FIELDS)-1:0] field_index;
        cmp_op_t                       op;
        logic [`FC_DATA_W-1:0]         value;
        logic                          filter_pass;
        logic                          conditional_flag;
        logic [`FC_ROUTE_W-1:0]        route_if;
        logic [`FC_ROUTE_W-1:0]        route_else;
    } filter_config_t;

    typedef struct packed {
        logic           valid;
        filter_config_t payload;
    } config_beat_t;

endpackage

/* verilog/filter_cond_settings.svh */
// Build-time sizes for the conditional filter stage.
// FC_PROG_THRESH must leave at least four free slots below FC_FIFO_DEPTH,
// because up to four packets can be popped before the first write lands.
`ifndef FILTER_COND_SETTINGS_SVH
`define FILTER_COND_SETTINGS_SVH

// Packet data layout
`define FC_DATA_W 32
`define FC_FIELDS 4

// Route identifier width
`define FC_ROUTE_W 8

// FIFO sizing
`define FC_FIFO_DEPTH 16
`define FC_PROG_THRESH 8

`endif
